//--- Makefile
VERILATOR  ?= verilator
TOP        := snake_tb
FILELIST   := project.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/snake_ref.svh
`ifndef SNAKE_REF_SVH
`define SNAKE_REF_SVH

// reference game model, works on the model state of the including module

function automatic int lfsr_shift(int v);
    int fb;
    fb = ((v >> 7) ^ (v >> 5) ^ (v >> 4) ^ (v >> 3)) & 1;
    return ((v << 1) & 8'hfe) | fb;
endfunction

function automatic direction_e turn_back(direction_e d);
    case (d)
        UP:      return DOWN;
        DOWN:    return UP;
        LEFT:    return RIGHT;
        default: return LEFT;
    endcase
endfunction

// the direction a step really takes when d is the pending press
function automatic direction_e applied_dir(direction_e d);
    return (d == turn_back(ref_heading)) ? ref_heading : d;
endfunction

function automatic void next_cell(direction_e d, output int nx, output int ny);
    nx = ref_x[0] + ((d == RIGHT) ? 1 : 0) - ((d == LEFT) ? 1 : 0);
    ny = ref_y[0] + ((d == DOWN) ? 1 : 0) - ((d == UP) ? 1 : 0);
endfunction

function automatic bit hits_border(direction_e d);
    int nx;
    int ny;
    next_cell(d, nx, ny);
    return nx < 0 || nx > 15 || ny < 0 || ny > 15;
endfunction

// the tail leaves its cell in the same step, so it does not count
function automatic bit hits_body(direction_e d);
    int nx;
    int ny;
    next_cell(d, nx, ny);
    for (int i = 0; i < ref_len - 1; i++) begin
        if (ref_x[i] == nx && ref_y[i] == ny) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic bit is_safe(direction_e d);
    return !hits_border(applied_dir(d)) && !hits_body(applied_dir(d));
endfunction

function automatic void model_reset();
    for (int i = 0; i < MAX_LENGTH; i++) begin
        ref_x[i] = 8 - ((i < 2) ? i : 2);
        ref_y[i] = 8;
    end
    ref_len = 3;
    ref_heading = RIGHT;
    ref_pending = RIGHT;
    ref_lfsr = 8'hA5;
    ref_ax = 5;
    ref_ay = 10;
    ref_score = 0;
endfunction

// one game step, returns 1 on a collision
function automatic bit model_step();
    direction_e d;
    int nx;
    int ny;
    d = applied_dir(ref_pending);
    ref_lfsr = lfsr_shift(ref_lfsr);
    ref_hit_self = hits_body(d);
    if (hits_border(d) || ref_hit_self) begin
        return 1'b1;
    end
    next_cell(d, nx, ny);
    for (int i = MAX_LENGTH - 1; i > 0; i--) begin
        ref_x[i] = ref_x[i-1];
        ref_y[i] = ref_y[i-1];
    end
    ref_x[0] = nx;
    ref_y[0] = ny;
    ref_heading = d;
    if (nx == ref_ax && ny == ref_ay) begin
        ref_score++;
        ref_ax = ref_lfsr & 15;
        ref_ay = ref_lfsr >> 4;
        if (ref_len < MAX_LENGTH) begin
            ref_len++;
        end
    end
    return 1'b0;
endfunction

// expected {apple, body, head} for one cell
function automatic logic [2:0] model_cell(int cx, int cy);
    logic [2:0] r;
    r = '0;
    r[2] = (cx == ref_ax && cy == ref_ay);
    r[0] = (cx == ref_x[0] && cy == ref_y[0]);
    for (int i = 1; i < ref_len; i++) begin
        if (cx == ref_x[i] && cy == ref_y[i]) begin
            r[1] = 1'b1;
        end
    end
    return r;
endfunction

`endif

//--- bench/snake_tb.sv
`timescale 1ns/100ps

module snake_tb import snake_pkg::*; ();

    localparam int MAX_LENGTH  = 30;
    localparam int STEP_CYCLES = 8;
    // all steps of all tests, pause periods included, plus room for presses
    localparam int TOTAL_STEPS = 260;
    localparam int LIMIT       = TOTAL_STEPS * STEP_CYCLES + 2000;

    logic        clk;
    logic        arst_n;
    logic [4:0]  btn;
    logic [3:0]  x;
    logic [3:0]  y;
    logic        apple;
    logic        body;
    logic        head;
    logic        gameover;
    logic [7:0]  score;
    game_state_e state;

    int          ref_x[MAX_LENGTH];
    int          ref_y[MAX_LENGTH];
    int          ref_len;
    int          ref_lfsr;
    int          ref_ax;
    int          ref_ay;
    int          ref_score;
    bit          ref_hit_self;
    direction_e  ref_heading;
    direction_e  ref_pending;
    game_state_e exp_state;

    bit          check_req;
    int          errors;
    int          test_errors;
    int          cycles;
    int          step_edge;
    int          pause_edge;

    `include "snake_ref.svh"

    tb_clock #(.PERIOD(20.0)) u_clock (.clk(clk));

    snake_top #(
        .MAX_LENGTH  (MAX_LENGTH),
        .STEP_CYCLES (STEP_CYCLES)
    ) u_dut (
        .clk                (clk),
        .arst_n             (arst_n),
        .button_up          (btn[4]),
        .button_down        (btn[3]),
        .button_left        (btn[2]),
        .button_right       (btn[1]),
        .button_start_pause (btn[0]),
        .x                  (x),
        .y                  (y),
        .apple              (apple),
        .body               (body),
        .head               (head),
        .gameover           (gameover),
        .score              (score),
        .state              (state)
    );

    task automatic check_val(string name, int exp, int got);
        assert (exp == got) else begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    // comparing process, pixel lookup is combinational so the scan runs between edges
    always begin
        logic [2:0] exp_cell;
        wait (check_req);
        check_val("state", int'(exp_state), int'(state));
        check_val("score", ref_score, score);
        check_val("gameover", exp_state == END_GAME, gameover);
        for (int cy = 0; cy < 16; cy++) begin
            for (int cx = 0; cx < 16; cx++) begin
                x = 4'(cx);
                y = 4'(cy);
                #0.1;
                exp_cell = model_cell(cx, cy);
                check_val($sformatf("{apple,body,head}(%0d,%0d)", cx, cy),
                          exp_cell, {apple, body, head});
            end
        end
        check_req = 1'b0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: no finish within %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic run_check();
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic press(int idx);
        @(posedge clk);
        #2;
        btn[idx] = 1'b1;
        @(posedge clk);
        #2;
        btn[idx] = 1'b0;
    endtask

    task automatic press_dir(direction_e d);
        case (d)
            UP:      press(4);
            DOWN:    press(3);
            LEFT:    press(2);
            default: press(1);
        endcase
        ref_pending = d;
    endtask

    // the step timer restarts on entry from WAIT and keeps its count across a pause
    task automatic wait_state(game_state_e s);
        do begin
            @(posedge clk);
            #2;
        end while (state != s);
        if (s == PAUSE) begin
            pause_edge = cycles;
        end else if (s == RUN && exp_state == PAUSE) begin
            step_edge += cycles - pause_edge;
        end else if (s == RUN) begin
            step_edge = cycles + STEP_CYCLES;
        end
        exp_state = s;
    endtask

    // the body moves on edge number step_edge, checked half a cycle later
    task automatic take_step(output bit died);
        died = model_step();
        while (cycles < step_edge) begin
            @(negedge clk);
        end
        step_edge += STEP_CYCLES;
        if (died) begin
            @(posedge clk);
            #2;
            exp_state = END_GAME;
        end
        run_check();
    endtask

    function automatic direction_e choose_dir(int tx, int ty);
        int pref[6];
        pref[0] = (tx > ref_x[0]) ? int'(RIGHT) : (tx < ref_x[0]) ? int'(LEFT) : -1;
        pref[1] = (ty > ref_y[0]) ? int'(DOWN) : (ty < ref_y[0]) ? int'(UP) : -1;
        for (int i = 2; i < 6; i++) begin
            pref[i] = i - 2;
        end
        foreach (pref[i]) begin
            if (pref[i] >= 0 && direction_e'(pref[i]) != turn_back(ref_heading)
                    && is_safe(direction_e'(pref[i]))) begin
                return direction_e'(pref[i]);
            end
        end
        return ref_heading;
    endfunction

    task automatic eat_apples(int count);
        bit died;
        int target;
        target = ref_score + count;
        for (int n = 0; n < 80 && ref_score < target; n++) begin
            press_dir(choose_dir(ref_ax, ref_ay));
            take_step(died);
        end
        if (ref_score < target) begin
            $display("snake did not reach the apple within 80 steps");
            errors++;
        end
    endtask

    task automatic end_test(string name);
        $display("test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        bit         died;
        direction_e d;
        int         n;
        arst_n = 1'b0;
        btn = '0;
        x = '0;
        y = '0;
        check_req = 1'b0;
        errors = 0;
        test_errors = 0;
        cycles = 0;
        step_edge = 0;
        pause_edge = 0;
        void'($urandom(78));
        model_reset();
        exp_state = WAIT;
        repeat (16) @(posedge clk);
        #2;
        arst_n = 1'b1;
        run_check();
        end_test("reset");

        press(0);
        wait_state(RUN);
        model_reset();
        for (int i = 0; i < 20; i++) begin
            d = direction_e'($urandom % 4);
            if (!is_safe(d)) begin
                d = choose_dir(ref_x[0], ref_y[0]);
            end
            press_dir(d);
            take_step(died);
        end
        end_test("move");

        eat_apples(2);
        end_test("apple");

        press(0);
        wait_state(PAUSE);
        repeat (4 * STEP_CYCLES) @(posedge clk);
        #2;
        run_check();
        press(0);
        wait_state(RUN);
        for (int i = 0; i < 3; i++) begin
            take_step(died);
        end
        end_test("pause");

        // straight ahead until the border stops the snake
        died = 1'b0;
        for (n = 0; n < 20 && !died; n++) begin
            take_step(died);
        end
        press(0);
        wait_state(WAIT);
        model_reset();
        run_check();
        press(0);
        wait_state(RUN);
        model_reset();
        eat_apples(2);
        for (n = 0; n < 20 && (ref_x[0] < 4 || ref_x[0] > 11 || ref_y[0] < 4
                || ref_y[0] > 11); n++) begin
            press_dir(choose_dir(8, 8));
            take_step(died);
        end
        // turning the same way three times runs the head into its own body
        died = 1'b0;
        for (n = 0; n < 5 && !died; n++) begin
            case (ref_heading)
                UP:      press_dir(RIGHT);
                RIGHT:   press_dir(DOWN);
                DOWN:    press_dir(LEFT);
                default: press_dir(UP);
            endcase
            take_step(died);
        end
        if (!died || !ref_hit_self) begin
            $display("snake did not run into itself while circling");
            errors++;
        end
        press(0);
        wait_state(WAIT);
        model_reset();
        run_check();
        end_test("collision");

        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2.0) clk = ~clk;
        end
    end

endmodule

//--- project.f
+incdir+include
verilog/grid_pkg.sv
verilog/snake_pkg.sv
verilog/button_decode.sv
verilog/game_control.sv
verilog/snake_body.sv
verilog/pixel_render.sv
verilog/snake_top.sv
bench/tb_clock.sv
bench/snake_tb.sv

//--- verilog/button_decode.sv
`timescale 1ns/100ps

module button_decode import snake_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  buttons,
    output button_cmd_t cmd
);

    logic [4:0] meta_q;
    logic [4:0] sync_q;
    logic [4:0] prev_q;
    logic [4:0] rise;

    // two-stage synchronizer, then one flop to remember the last level
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= buttons;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    // a held button gives a single pulse
    assign rise = sync_q & ~prev_q;

    assign cmd = button_cmd_t'(rise);

endmodule

//--- verilog/game_control.sv
`timescale 1ns/100ps

module game_control import snake_pkg::*; #(
    parameter int STEP_CYCLES = 1000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  button_cmd_t cmd,
    input  logic        dead,
    output game_state_e state,
    output logic        step,
    output logic        clear
);

    localparam int CNT_W = $clog2(STEP_CYCLES + 1);

    game_state_e      state_q;
    game_state_e      state_d;
    logic [CNT_W-1:0] cnt_q;
    logic             last_cnt;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WAIT: begin
                if (cmd.start_pause) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                // a collision wins over a pause press in the same cycle
                if (dead) begin
                    state_d = END_GAME;
                end else if (cmd.start_pause) begin
                    state_d = PAUSE;
                end
            end
            PAUSE: begin
                if (cmd.start_pause) begin
                    state_d = RUN;
                end
            end
            default: begin
                if (cmd.start_pause) begin
                    state_d = WAIT;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= WAIT;
        end else begin
            state_q <= state_d;
        end
    end

    assign last_cnt = (cnt_q == CNT_W'(STEP_CYCLES - 1));

    // step timer, held in PAUSE and restarted from zero in WAIT and END_GAME
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
        end else if (state_q == RUN) begin
            cnt_q <= last_cnt ? '0 : cnt_q + 1'b1;
        end else if (state_q != PAUSE) begin
            cnt_q <= '0;
        end
    end

    assign step  = (state_q == RUN) && last_cnt;
    assign clear = cmd.start_pause && (state_q == WAIT || state_q == END_GAME);
    assign state = state_q;

    a_step_in_run: assert property (@(posedge clk) disable iff (!arst_n)
        step |-> state_q == RUN);

endmodule

//--- verilog/grid_pkg.sv
package grid_pkg;

    // square board, one coordinate per axis
    localparam int GRID_SIZE = 16;
    localparam int COORD_W = $clog2(GRID_SIZE);

    typedef logic [COORD_W-1:0] coord_t;

    localparam coord_t COORD_MAX = coord_t'(GRID_SIZE - 1);

    // y sits in the high nibble so an 8-bit value maps straight onto a cell
    typedef struct packed {
        coord_t y;
        coord_t x;
    } cell_t;

endpackage

//--- verilog/pixel_render.sv
`timescale 1ns/100ps

module pixel_render import grid_pkg::*; #(
    parameter int MAX_LENGTH = 30
) (
    input  cell_t                  query,
    input  cell_t [MAX_LENGTH-1:0] body_pos,
    input  logic [4:0]             length,
    input  cell_t                  apple,
    output logic                   apple_hit,
    output logic                   body_hit,
    output logic                   head_hit
);

    assign apple_hit = (query == apple);

    // segment 0 is always the head
    assign head_hit = (query == body_pos[0]);

    always_comb begin
        body_hit = 1'b0;
        for (int i = 1; i < MAX_LENGTH; i++) begin
            if (i < int'(length) && body_pos[i] == query) begin
                body_hit = 1'b1;
            end
        end
    end

endmodule

//--- verilog/snake_body.sv
`timescale 1ns/100ps

module snake_body import grid_pkg::*, snake_pkg::*; #(
    parameter int MAX_LENGTH = 30
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  button_cmd_t            cmd,
    input  logic                   step,
    input  logic                   clear,
    output logic                   dead,
    output cell_t [MAX_LENGTH-1:0] body_pos,
    output logic [4:0]             length,
    output cell_t                  apple,
    output logic [7:0]             score
);

    localparam logic [7:0] LFSR_SEED = 8'hA5;
    localparam coord_t     START_X   = 4'd8;
    localparam coord_t     START_Y   = 4'd8;
    localparam logic [4:0] START_LEN = 5'd3;

    cell_t [MAX_LENGTH-1:0] body_q;
    logic [4:0]             len_q;
    direction_e             heading_q;
    direction_e             pending_q;
    direction_e             dir;
    logic [7:0]             lfsr_q;
    logic [7:0]             lfsr_next;
    cell_t                  apple_q;
    logic [7:0]             score_q;
    logic                   dead_q;
    cell_t                  head_next;
    logic                   hit_border;
    logic                   hit_self;
    logic                   collide;
    logic                   eat;

    // start snake lies left of the head, unused slots repeat the tail
    function automatic cell_t start_seg(int idx);
        cell_t seg;
        int    off;
        off = (idx < int'(START_LEN)) ? idx : int'(START_LEN) - 1;
        seg.y = START_Y;
        seg.x = START_X - coord_t'(off);
        return seg;
    endfunction

    // latest press wins, pulses are taken in every state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= RIGHT;
        end else if (clear) begin
            pending_q <= RIGHT;
        end else if (cmd.up) begin
            pending_q <= UP;
        end else if (cmd.down) begin
            pending_q <= DOWN;
        end else if (cmd.left) begin
            pending_q <= LEFT;
        end else if (cmd.right) begin
            pending_q <= RIGHT;
        end
    end

    always_comb begin
        // a reversal would run into the neck, keep going straight
        dir = (pending_q == opposite(heading_q)) ? heading_q : pending_q;
        head_next = body_q[0];
        case (dir)
            UP: begin
                hit_border = (body_q[0].y == '0);
                head_next.y = body_q[0].y - 1'b1;
            end
            DOWN: begin
                hit_border = (body_q[0].y == COORD_MAX);
                head_next.y = body_q[0].y + 1'b1;
            end
            LEFT: begin
                hit_border = (body_q[0].x == '0);
                head_next.x = body_q[0].x - 1'b1;
            end
            default: begin
                hit_border = (body_q[0].x == COORD_MAX);
                head_next.x = body_q[0].x + 1'b1;
            end
        endcase
    end

    // the current tail is treated as a free cell
    always_comb begin
        hit_self = 1'b0;
        for (int i = 0; i < MAX_LENGTH - 1; i++) begin
            if (i < int'(len_q) - 1 && body_q[i] == head_next) begin
                hit_self = 1'b1;
            end
        end
    end

    assign collide   = hit_border || hit_self;
    assign eat       = (head_next == apple_q);
    assign lfsr_next = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MAX_LENGTH; i++) begin
                body_q[i] <= start_seg(i);
            end
            len_q     <= START_LEN;
            heading_q <= RIGHT;
            lfsr_q    <= LFSR_SEED;
            apple_q   <= cell_t'(LFSR_SEED);
            score_q   <= '0;
            dead_q    <= 1'b0;
        end else if (clear) begin
            for (int i = 0; i < MAX_LENGTH; i++) begin
                body_q[i] <= start_seg(i);
            end
            len_q     <= START_LEN;
            heading_q <= RIGHT;
            lfsr_q    <= LFSR_SEED;
            apple_q   <= cell_t'(LFSR_SEED);
            score_q   <= '0;
            dead_q    <= 1'b0;
        end else begin
            dead_q <= step && collide;
            if (step) begin
                lfsr_q <= lfsr_next;
                if (!collide) begin
                    // growing keeps the old tail, it lands in the next slot
                    for (int i = MAX_LENGTH - 1; i > 0; i--) begin
                        body_q[i] <= body_q[i-1];
                    end
                    body_q[0] <= head_next;
                    heading_q <= dir;
                    if (eat) begin
                        score_q <= score_q + 1'b1;
                        apple_q <= cell_t'(lfsr_next);
                        if (len_q < 5'(MAX_LENGTH)) begin
                            len_q <= len_q + 1'b1;
                        end
                    end
                end
            end
        end
    end

    assign dead     = dead_q;
    assign body_pos = body_q;
    assign length   = len_q;
    assign apple    = apple_q;
    assign score    = score_q;

    a_length_range: assert property (@(posedge clk) disable iff (!arst_n)
        len_q >= START_LEN && len_q <= 5'(MAX_LENGTH));

    a_dead_after_step: assert property (@(posedge clk) disable iff (!arst_n)
        dead_q |-> $past(step));

endmodule

//--- verilog/snake_pkg.sv
package snake_pkg;

    typedef enum logic [1:0] {
        RUN      = 2'b00,
        WAIT     = 2'b01,
        PAUSE    = 2'b10,
        END_GAME = 2'b11
    } game_state_e;

    // y grows downwards, so UP lowers y
    typedef enum logic [1:0] {
        UP    = 2'b00,
        DOWN  = 2'b01,
        LEFT  = 2'b10,
        RIGHT = 2'b11
    } direction_e;

    // one-cycle pulses, field order matches the raw button bus
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic start_pause;
    } button_cmd_t;

    function automatic direction_e opposite(direction_e dir);
        direction_e rev;
        case (dir)
            UP:      rev = DOWN;
            DOWN:    rev = UP;
            LEFT:    rev = RIGHT;
            default: rev = LEFT;
        endcase
        return rev;
    endfunction

endpackage

//--- verilog/snake_top.sv
`timescale 1ns/100ps

module snake_top import grid_pkg::*, snake_pkg::*; #(
    parameter int MAX_LENGTH  = 30,
    parameter int STEP_CYCLES = 1000
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        button_up,
    input  logic        button_down,
    input  logic        button_left,
    input  logic        button_right,
    input  logic        button_start_pause,
    input  coord_t      x,
    input  coord_t      y,
    output logic        apple,
    output logic        body,
    output logic        head,
    output logic        gameover,
    output logic [7:0]  score,
    output game_state_e state
);

    button_cmd_t            cmd;
    logic                   step;
    logic                   clear;
    logic                   dead;
    cell_t [MAX_LENGTH-1:0] body_pos;
    logic [4:0]             length;
    cell_t                  apple_cell;
    cell_t                  query;

    assign query = cell_t'{x: x, y: y};

    button_decode u_decode (
        .clk     (clk),
        .arst_n  (arst_n),
        .buttons ({button_up, button_down, button_left, button_right, button_start_pause}),
        .cmd     (cmd)
    );

    game_control #(
        .STEP_CYCLES (STEP_CYCLES)
    ) u_control (
        .clk    (clk),
        .arst_n (arst_n),
        .cmd    (cmd),
        .dead   (dead),
        .state  (state),
        .step   (step),
        .clear  (clear)
    );

    snake_body #(
        .MAX_LENGTH (MAX_LENGTH)
    ) u_body (
        .clk      (clk),
        .arst_n   (arst_n),
        .cmd      (cmd),
        .step     (step),
        .clear    (clear),
        .dead     (dead),
        .body_pos (body_pos),
        .length   (length),
        .apple    (apple_cell),
        .score    (score)
    );

    pixel_render #(
        .MAX_LENGTH (MAX_LENGTH)
    ) u_render (
        .query     (query),
        .body_pos  (body_pos),
        .length    (length),
        .apple     (apple_cell),
        .apple_hit (apple),
        .body_hit  (body),
        .head_hit  (head)
    );

    assign gameover = (state == END_GAME);

endmodule
